// File: tb/hm_reader_input.txt
// columns: address, stall (0 none, 1 random, 2 forced), link down, drop pulses, repeat, status
// status 0 ok, 1 timeout, 2 link down; a stall value of f ends the list
0000000000001000 0 0 0 1 0
00000000fffffffc 0 0 1 1 0
0000000100000000 0 0 0 1 0
123456789abcdef0 0 0 2 1 0
0000000080000040 1 0 0 1 0
ffffffff00000008 1 0 3 1 0
0000000000002000 2 0 0 1 1
0000000000002040 0 0 1 1 0
0000000000003000 0 1 0 1 2
0000000200000000 0 1 2 1 2
0000000000004000 0 0 0 1 0
00000000deadbee0 1 0 4 1 0
0000000000010000 0 0 0 f0 0
8000000000000000 0 0 0 1 0
0000000000005000 2 0 2 1 1
00000000000050c0 1 0 0 4 0
0000000000006000 0 1 0 1 2
00000000ffffffff 1 0 1 1 0
0000000100000004 0 0 5 1 0
0000000000007000 0 0 0 1 0
0000000000000000 f 0 0 0 0

// File: hm_reader.f
logic/hm_pkg.sv
logic/hm_req_ctrl.sv
logic/hm_tlp_build.sv
logic/hm_tx.sv
logic/hm_reader.sv
tb/trn_sink_model.sv
tb/hm_reader_tb.sv

// File: Makefile
# Verilator build and run of the hm_reader testbench
TOP := hm_reader_tb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

build:
	verilator --binary --timing --timescale 1ns/1ps -f hm_reader.f \
	  --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps logic/hm_pkg.sv \
	  logic/hm_req_ctrl.sv logic/hm_tlp_build.sv logic/hm_tx.sv \
	  logic/hm_reader.sv --top-module hm_reader

clean:
	rm -rf obj_dir

// File: tb/hm_reader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hm_reader_tb import hm_pkg::*; ();

  logic        trn_clk;
  logic        arst_n;
  logic        req;
  hm_cmd_t     cmd;
  logic        ack;
  hm_rsp_t     rsp;
  cfg_id_t     cfg_id;
  logic        trn_lnk_up_n;
  trn_tx_t     trn_tx;
  wire         trn_tdst_rdy_n;
  wire         trn_terr_drop_n;
  logic [31:0] stat_tx;
  logic [31:0] stat_drop;
  logic [1:0]  stall_mode;
  logic        drop_load;
  logic [7:0]  drop_num;
  wire         drops_pending;

  logic [63:0] vec_mem [0:255];  // six words per line of the input file
  logic [7:0]  next_tag;
  logic [7:0]  last_tag;
  logic [31:0] exp_sent;
  logic [31:0] exp_drops;
  int unsigned err_beat;
  int unsigned err_rsp;
  int unsigned err_count;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;

  hm_reader u_dut (
    .trn_clk         (trn_clk),
    .arst_n          (arst_n),
    .req             (req),
    .cmd             (cmd),
    .ack             (ack),
    .rsp             (rsp),
    .cfg_id          (cfg_id),
    .trn_lnk_up_n    (trn_lnk_up_n),
    .trn_tx          (trn_tx),
    .trn_tdst_rdy_n  (trn_tdst_rdy_n),
    .trn_terr_drop_n (trn_terr_drop_n),
    .stat_tx         (stat_tx),
    .stat_drop       (stat_drop)
  );

  trn_sink_model u_sink (
    .trn_clk       (trn_clk),
    .arst_n        (arst_n),
    .trn_tx        (trn_tx),
    .tdst_rdy_n    (trn_tdst_rdy_n),
    .terr_drop_n   (trn_terr_drop_n),
    .stall_mode    (stall_mode),
    .drop_load     (drop_load),
    .drop_num      (drop_num),
    .drops_pending (drops_pending)
  );

  initial begin
    trn_clk = 1'b0;
    forever #10 trn_clk = ~trn_clk;
  end

  always @(posedge trn_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("the run hung: request list not finished after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_beat(input trn_tx_t got, input trn_tx_t exp, input string what);
    if (got !== exp) begin
      err_beat++;
      $display("CHECK FAILED at %0t: %s got td %h sof_n %b eof_n %b rem_n %b src_rdy_n %b",
        $time, what, got.td, got.sof_n, got.eof_n, got.rem_n, got.src_rdy_n);
      $display("  expected td %h sof_n %b eof_n %b rem_n %b src_rdy_n %b",
        exp.td, exp.sof_n, exp.eof_n, exp.rem_n, exp.src_rdy_n);
    end
  endtask

  task automatic check_rsp(input hm_rsp_t got, input hm_rsp_t exp, input string what);
    if (got !== exp) begin
      err_rsp++;
      $display("CHECK FAILED at %0t: %s got %s tag %0d, expected %s tag %0d", $time, what,
        got.status.name(), got.tag, exp.status.name(), exp.tag);
    end
  endtask

  task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // header qword 0 as the TLP rules lay it out
  function automatic trn_tx_t header_beat(input logic [63:0] addr, input logic [7:0] tag);
    hm_hdr0_t hdr;
    hdr = '{fmt: (addr[63:32] != 32'd0) ? hm_fmt_4dw : hm_fmt_3dw, tlp_type: hm_type_mrd,
            rsvd_byte: 8'd0, rsvd: 4'd0, at: 2'd0, length: hm_req_len,
            requester_id: cfg_id, tag: tag, last_be: hm_be_all, first_be: hm_be_all};
    return '{td: hdr, sof_n: 1'b0, eof_n: 1'b1, rem_n: 1'b1, src_rdy_n: 1'b0};
  endfunction

  function automatic trn_tx_t address_beat(input logic [63:0] addr);
    logic four_dw;
    four_dw = (addr[63:32] != 32'd0);
    return '{td: four_dw ? addr : {addr[31:0], 32'd0}, sof_n: 1'b1, eof_n: 1'b0,
             rem_n: !four_dw, src_rdy_n: 1'b0};
  endfunction

  task automatic run_request(input logic [63:0] addr, input logic [1:0] mode,
                             input logic link_down, input logic [7:0] drops,
                             input hm_status_e exp_status);
    hm_rsp_t     exp_rsp;
    int unsigned n_beats;
    n_beats = (exp_status == st_ok) ? 2 : 0;
    cmd.addr     = addr;
    stall_mode   = mode;
    trn_lnk_up_n = link_down;
    drop_num     = drops;
    drop_load    = 1'b1;
    req          = 1'b1;
    exp_drops    = exp_drops + {24'd0, drops};
    @(negedge trn_clk);
    drop_load = 1'b0;
    while (ack !== 1'b1) @(negedge trn_clk);
    exp_rsp.status = exp_status;
    if (link_down) begin
      exp_rsp.tag = last_tag;  // refused request takes no tag
    end else begin
      exp_rsp.tag = next_tag;
      last_tag    = next_tag;
      next_tag    = next_tag + 8'd1;
    end
    if (exp_status == st_ok) exp_sent = exp_sent + 32'd1;
    check_rsp(rsp, exp_rsp, "response");
    check_count(32'(u_sink.beats.size()), n_beats, "captured beats");
    if (u_sink.beats.size() == n_beats && n_beats == 2) begin
      check_beat(u_sink.beats.pop_front(), header_beat(addr, exp_rsp.tag), "beat 0");
      check_beat(u_sink.beats.pop_front(), address_beat(addr), "beat 1");
    end
    u_sink.beats.delete();
    check_count(stat_tx, exp_sent, "stat_tx");
    req = 1'b0;
    while (ack !== 1'b0) @(negedge trn_clk);
  endtask

  initial begin : main
    int unsigned n_req;
    int unsigned rep;
    logic [7:0]  base;
    logic [63:0] addr;
    void'($urandom(32'h867fe542));
    arst_n       = 1'b0;
    req          = 1'b0;
    cmd          = '0;
    cfg_id       = '{bus: 8'h3a, device: 5'd7, func: 3'd2};
    trn_lnk_up_n = 1'b0;
    stall_mode   = 2'd0;
    drop_load    = 1'b0;
    drop_num     = 8'd0;
    next_tag     = 8'd0;
    last_tag     = 8'd0;
    exp_sent     = 32'd0;
    exp_drops    = 32'd0;
    err_beat     = 0;
    err_rsp      = 0;
    err_count    = 0;
    $readmemh("tb/hm_reader_input.txt", vec_mem);
    n_req = 0;
    base  = 8'd0;
    while (vec_mem[base + 8'd1] !== 64'hf && base < 8'd240) begin
      n_req = n_req + vec_mem[base + 8'd4][31:0];
      base  = base + 8'd6;
    end
    cycle_limit = n_req * (32'(hm_stall_limit) + 32'd200);
    repeat (16) @(posedge trn_clk);
    @(negedge trn_clk);
    arst_n = 1'b1;
    @(negedge trn_clk);
    check_count({31'd0, ack}, 32'd0, "ack after reset");
    check_count({28'd0, trn_tx.sof_n, trn_tx.eof_n, trn_tx.rem_n, trn_tx.src_rdy_n}, 32'hf,
      "trn strobes after reset");
    check_count(stat_tx, 32'd0, "stat_tx after reset");
    base = 8'd0;
    while (vec_mem[base + 8'd1] !== 64'hf && base < 8'd240) begin
      addr = vec_mem[base];
      for (rep = 0; rep < vec_mem[base + 8'd4][31:0]; rep++) begin
        run_request(addr + 64'(rep) * 64'h40, vec_mem[base + 8'd1][1:0],
          vec_mem[base + 8'd2][0], vec_mem[base + 8'd3][7:0],
          hm_status_e'(vec_mem[base + 8'd5][1:0]));
        @(negedge trn_clk);
      end
      base = base + 8'd6;
    end
    while (drops_pending) @(negedge trn_clk);
    repeat (2) @(negedge trn_clk);
    check_count(stat_drop, exp_drops, "stat_drop");
    $display("errors: beat %0d, response %0d, count %0d", err_beat, err_rsp, err_count);
    if (err_beat + err_rsp + err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/trn_sink_model.sv
`timescale 1ns/1ps
`default_nettype none

module trn_sink_model import hm_pkg::*; (
  input  wire        trn_clk,
  input  wire        arst_n,
  input  trn_tx_t    trn_tx,
  output wire        tdst_rdy_n,
  output wire        terr_drop_n,
  // control from the testbench
  input  wire  [1:0] stall_mode,  // 0 none, 1 random, 2 forced
  input  wire        drop_load,
  input  wire  [7:0] drop_num,
  output wire        drops_pending
);

  trn_tx_t     beats[$];  // transferred beats, oldest first
  logic [1:0]  mode_q;
  logic [15:0] drops_left;
  logic        drop_now;
  logic        rdy_n_q = 1'b1;
  logic        drop_n_q = 1'b1;

  assign tdst_rdy_n    = rdy_n_q;
  assign terr_drop_n   = drop_n_q;
  assign drops_pending = (drops_left != 16'd0) || drop_now || !drop_n_q;

  // a beat moves when both sides are ready
  always @(posedge trn_clk) begin
    if (!trn_tx.src_rdy_n && !rdy_n_q) begin
      beats.push_back(trn_tx);
    end
  end

  always @(posedge trn_clk or negedge arst_n) begin : drop_seq
    logic [15:0] left;
    if (!arst_n) begin
      mode_q     <= 2'd0;
      drops_left <= 16'd0;
      drop_now   <= 1'b0;
    end else begin
      mode_q <= stall_mode;
      left = drops_left + (drop_load ? {8'd0, drop_num} : 16'd0);
      if (!drop_now && left != 16'd0) begin
        drop_now <= 1'b1;  // one cycle low, then at least one high
        left = left - 16'd1;
      end else begin
        drop_now <= 1'b0;
      end
      drops_left <= left;
    end
  end

  // outputs change on the falling edge only
  always @(negedge trn_clk) begin
    drop_n_q <= !drop_now;
    case (mode_q)
      2'd1: rdy_n_q <= ($urandom % 32'd3) == 32'd0;  // about a third stalled
      2'd2: rdy_n_q <= 1'b1;
      default: rdy_n_q <= 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/hm_reader.sv
`timescale 1ns/1ps
`default_nettype none

module hm_reader import hm_pkg::*; (
  input  wire         trn_clk,
  input  wire         arst_n,
  // client
  input  wire         req,
  input  hm_cmd_t     cmd,
  output logic        ack,
  output hm_rsp_t     rsp,
  // configuration and link
  input  cfg_id_t     cfg_id,
  input  wire         trn_lnk_up_n,
  // TRN transmit
  output trn_tx_t     trn_tx,
  input  wire         trn_tdst_rdy_n,
  input  wire         trn_terr_drop_n,
  // statistics
  output logic [31:0] stat_tx,
  output logic [31:0] stat_drop
);

  logic        start;
  logic [63:0] addr;
  logic        hdr_vld;
  hm_hdr0_t    hdr0;
  hm_qw1_u     qw1;
  logic        is_4dw;
  logic [7:0]  tag;
  logic        done;
  logic        timed_out;

  hm_req_ctrl u_ctrl (
    .trn_clk   (trn_clk),
    .arst_n    (arst_n),
    .req       (req),
    .cmd       (cmd),
    .ack       (ack),
    .rsp       (rsp),
    .lnk_up_n  (trn_lnk_up_n),
    .start     (start),
    .addr      (addr),
    .tag       (tag),
    .done      (done),
    .timed_out (timed_out)
  );

  hm_tlp_build u_build (
    .trn_clk (trn_clk),
    .arst_n  (arst_n),
    .start   (start),
    .addr    (addr),
    .cfg_id  (cfg_id),
    .hdr_vld (hdr_vld),
    .hdr0    (hdr0),
    .qw1     (qw1),
    .is_4dw  (is_4dw),
    .tag     (tag)
  );

  hm_tx u_tx (
    .trn_clk     (trn_clk),
    .arst_n      (arst_n),
    .hdr_vld     (hdr_vld),
    .hdr0        (hdr0),
    .qw1         (qw1),
    .is_4dw      (is_4dw),
    .trn_tx      (trn_tx),
    .tdst_rdy_n  (trn_tdst_rdy_n),
    .terr_drop_n (trn_terr_drop_n),
    .done        (done),
    .timed_out   (timed_out),
    .stat_tx     (stat_tx),
    .stat_drop   (stat_drop)
  );

endmodule

`default_nettype wire

// File: logic/hm_tx.sv
`timescale 1ns/1ps
`default_nettype none

module hm_tx import hm_pkg::*; (
  input  wire         trn_clk,
  input  wire         arst_n,
  // header from the builder
  input  wire         hdr_vld,
  input  hm_hdr0_t    hdr0,
  input  hm_qw1_u     qw1,
  input  wire         is_4dw,
  // TRN transmit side
  output trn_tx_t     trn_tx,
  input  wire         tdst_rdy_n,
  input  wire         terr_drop_n,
  // status back to the controller
  output logic        done,
  output logic        timed_out,
  // statistics
  output logic [31:0] stat_tx,
  output logic [31:0] stat_drop
);

  logic        active;     // a beat is pending
  logic        beat;       // 0 header qword, 1 address qword
  logic [15:0] stall_cnt;
  logic        xfer;
  logic        stall_end;

  logic [63:0] td_q;
  logic        sof_n_q;
  logic        eof_n_q;
  logic        rem_n_q;
  logic        src_rdy_n_q;

  assign xfer      = active && !tdst_rdy_n;
  assign stall_end = active && tdst_rdy_n && (stall_cnt == hm_stall_limit - 16'd1);

  assign trn_tx = '{
    td:        td_q,
    sof_n:     sof_n_q,
    eof_n:     eof_n_q,
    rem_n:     rem_n_q,
    src_rdy_n: src_rdy_n_q
  };

  // framing strobes and beat sequencing
  always_ff @(posedge trn_clk or negedge arst_n) begin
    if (!arst_n) begin
      active      <= 1'b0;
      beat        <= 1'b0;
      stall_cnt   <= 16'd0;
      sof_n_q     <= 1'b1;
      eof_n_q     <= 1'b1;
      rem_n_q     <= 1'b1;
      src_rdy_n_q <= 1'b1;
      done        <= 1'b0;
      timed_out   <= 1'b0;
    end else begin
      done      <= 1'b0;
      timed_out <= 1'b0;
      if (!active) begin
        if (hdr_vld) begin  // present beat 0
          active      <= 1'b1;
          beat        <= 1'b0;
          stall_cnt   <= 16'd0;
          sof_n_q     <= 1'b0;
          eof_n_q     <= 1'b1;
          rem_n_q     <= 1'b1;
          src_rdy_n_q <= 1'b0;
        end
      end else if (xfer) begin
        stall_cnt <= 16'd0;
        if (!beat) begin
          beat    <= 1'b1;
          sof_n_q <= 1'b1;
          eof_n_q <= 1'b0;
          rem_n_q <= !is_4dw;  // 3DW leaves the low dword empty
        end else begin
          active      <= 1'b0;
          eof_n_q     <= 1'b1;
          rem_n_q     <= 1'b1;
          src_rdy_n_q <= 1'b1;
          done        <= 1'b1;
        end
      end else if (stall_end) begin
        // destination stuck, give up on the frame
        active      <= 1'b0;
        sof_n_q     <= 1'b1;
        eof_n_q     <= 1'b1;
        rem_n_q     <= 1'b1;
        src_rdy_n_q <= 1'b1;
        done        <= 1'b1;
        timed_out   <= 1'b1;
      end else begin
        stall_cnt <= stall_cnt + 16'd1;
      end
    end
  end

  // beat data, held under back-pressure
  always_ff @(posedge trn_clk) begin
    if (!active && hdr_vld) begin
      td_q <= hdr0;
    end else if (xfer && !beat) begin
      td_q <= qw1.addr64;
    end
  end

  // statistics
  always_ff @(posedge trn_clk or negedge arst_n) begin
    if (!arst_n) begin
      stat_tx   <= 32'd0;
      stat_drop <= 32'd0;
    end else begin
      if (xfer && beat) begin
        stat_tx <= stat_tx + 32'd1;  // completed frames only
      end
      if (!terr_drop_n) begin
        stat_drop <= stat_drop + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/hm_tlp_build.sv
`timescale 1ns/1ps
`default_nettype none

module hm_tlp_build import hm_pkg::*; (
  input  wire         trn_clk,
  input  wire         arst_n,
  input  wire         start,
  input  wire  [63:0] addr,
  input  cfg_id_t     cfg_id,
  output logic        hdr_vld,
  output hm_hdr0_t    hdr0,
  output hm_qw1_u     qw1,
  output logic        is_4dw,
  output logic [7:0]  tag
);

  logic [7:0] tag_cnt;  // next tag to hand out
  logic       above_4g;

  assign above_4g = (addr[63:32] != 32'd0);

  always_ff @(posedge trn_clk or negedge arst_n) begin
    if (!arst_n) begin
      hdr_vld <= 1'b0;
      tag_cnt <= 8'd0;
      tag     <= 8'd0;
    end else begin
      hdr_vld <= start;
      if (start) begin
        tag     <= tag_cnt;
        tag_cnt <= tag_cnt + 8'd1;  // wraps at 256
      end
    end
  end

  // header words, stable until the next start
  always_ff @(posedge trn_clk) begin
    if (start) begin
      hdr0.fmt          <= above_4g ? hm_fmt_4dw : hm_fmt_3dw;
      hdr0.tlp_type     <= hm_type_mrd;
      hdr0.rsvd_byte    <= 8'd0;
      hdr0.rsvd         <= 4'd0;
      hdr0.at           <= 2'b00;
      hdr0.length       <= hm_req_len;
      hdr0.requester_id <= cfg_id;
      hdr0.tag          <= tag_cnt;
      hdr0.last_be      <= hm_be_all;
      hdr0.first_be     <= hm_be_all;
      is_4dw            <= above_4g;
      if (above_4g) begin
        qw1.addr64 <= addr;
      end else begin
        qw1.dw3.addr_lo <= addr[31:0];
        qw1.dw3.pad     <= 32'd0;  // unused dword of the beat
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/hm_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hm_req_ctrl import hm_pkg::*; (
  input  wire         trn_clk,
  input  wire         arst_n,
  // client handshake
  input  wire         req,
  input  hm_cmd_t     cmd,
  output logic        ack,
  output hm_rsp_t     rsp,
  // link state
  input  wire         lnk_up_n,
  // towards the header builder
  output logic        start,
  output logic [63:0] addr,
  input  wire  [7:0]  tag,
  // back from the framer
  input  wire         done,
  input  wire         timed_out
);

  typedef enum logic [1:0] {
    s_idle,
    s_busy,
    s_answer
  } ctrl_state_e;

  ctrl_state_e state;
  logic        req_q;  // registered request
  logic        launch;
  logic        refuse;
  logic        finish;

  assign launch = (state == s_idle) && req_q && !lnk_up_n;
  assign refuse = (state == s_idle) && req_q && lnk_up_n;  // link down, no frame
  assign finish = (state == s_busy) && done;

  always_ff @(posedge trn_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= s_idle;
      req_q <= 1'b0;
      ack   <= 1'b0;
      start <= 1'b0;
    end else begin
      req_q <= req;
      start <= launch;
      case (state)
        s_idle: begin
          if (launch) begin
            state <= s_busy;
          end else if (refuse) begin
            state <= s_answer;
            ack   <= 1'b1;
          end
        end
        s_busy: begin
          if (finish) begin
            state <= s_answer;
            ack   <= 1'b1;
          end
        end
        default: begin
          // wait for the client to drop req
          if (!req_q) begin
            state <= s_idle;
            ack   <= 1'b0;
          end
        end
      endcase
    end
  end

  // address latch and response, held while ack is up
  always_ff @(posedge trn_clk) begin
    if (launch) begin
      addr <= cmd.addr;
    end
    if (refuse) begin
      rsp.status <= st_link_down;
      rsp.tag    <= tag;  // last issued tag, nothing consumed
    end else if (finish) begin
      rsp.status <= timed_out ? st_timeout : st_ok;
      rsp.tag    <= tag;
    end
  end

endmodule

`default_nettype wire

// File: logic/hm_pkg.sv
`default_nettype none

package hm_pkg;

  // TLP header constants
  localparam logic [2:0] hm_fmt_3dw = 3'b000;  // 3DW header, no data
  localparam logic [2:0] hm_fmt_4dw = 3'b001;  // 4DW header, no data
  localparam logic [4:0] hm_type_mrd = 5'b00000;  // memory read
  localparam logic [9:0] hm_req_len = 10'd0;  // zero encodes 1024 dwords
  localparam logic [3:0] hm_be_all = 4'hf;

  // consecutive stalled cycles before a frame is dropped
  localparam logic [15:0] hm_stall_limit = 16'd48;

  typedef struct packed {
    logic [7:0] bus;
    logic [4:0] device;
    logic [2:0] func;
  } cfg_id_t;

  // header qword 0, first on the wire
  typedef struct packed {
    logic [2:0] fmt;
    logic [4:0] tlp_type;
    logic [7:0] rsvd_byte;
    logic [3:0] rsvd;
    logic [1:0] at;  // address type, untranslated
    logic [9:0] length;
    cfg_id_t    requester_id;
    logic [7:0] tag;
    logic [3:0] last_be;
    logic [3:0] first_be;
  } hm_hdr0_t;

  typedef struct packed {
    logic [31:0] addr_lo;
    logic [31:0] pad;
  } hm_qw1_3dw_t;

  // qword 1 is a full address for 4DW, low dword plus padding for 3DW
  typedef union packed {
    logic [63:0] addr64;
    hm_qw1_3dw_t dw3;
  } hm_qw1_u;

  typedef struct packed {
    logic [63:0] addr;
  } hm_cmd_t;

  typedef enum logic [1:0] {
    st_ok,
    st_timeout,
    st_link_down
  } hm_status_e;

  typedef struct packed {
    hm_status_e status;
    logic [7:0] tag;
  } hm_rsp_t;

  typedef struct packed {
    logic [63:0] td;
    logic        sof_n;
    logic        eof_n;
    logic        rem_n;  // low when both dwords valid
    logic        src_rdy_n;
  } trn_tx_t;

endpackage

`default_nettype wire
